/* bench/pid_checker.sv */
`timescale 1ns/1ns
`include "pid_macros.svh"

module pid_checker (
    input  logic                                       sys_clk_in,
    input  logic                                       rst_in,
    input  logic                                       res_valid,
    input  logic                                       out_valid,
    input  logic                                       out_credit,
    input  logic                                       in_credit,
    input  logic [$clog2(`PID_SINK_CREDITS + 1)-1:0]   sink_credits,
    input  logic [$clog2(`PID_FIFO_DEPTH + 1)-1:0]     fifo_cnt
);

    localparam int W_CRED = $clog2(`PID_SINK_CREDITS + 1);

    // Sink credits as seen on the pins
    logic [W_CRED-1:0] held_credits;

    always_ff @(posedge sys_clk_in) begin
        if (rst_in) begin
            held_credits <= W_CRED'(`PID_SINK_CREDITS);
        end else begin
            held_credits <= held_credits + W_CRED'(out_credit) - W_CRED'(out_valid);
        end
    end

    // --------------------------------------------------
    // Sink side
    // A pop spends a held credit
    a_pop_needs_credit: assert property (
        @(posedge sys_clk_in) disable iff (rst_in) out_valid |-> (held_credits != '0)
    ) else $error("out_valid asserted with no sink credit held");

    // Sink returns no more than it was given
    a_credit_bound: assert property (
        @(posedge sys_clk_in) disable iff (rst_in) sink_credits <= `PID_SINK_CREDITS
    ) else $error("sink credit count above its initial value");

    // --------------------------------------------------
    // FIFO and source side
    a_fifo_bound: assert property (
        @(posedge sys_clk_in) disable iff (rst_in) fifo_cnt <= `PID_FIFO_DEPTH
    ) else $error("FIFO occupancy above its depth");

    // Every pop frees one slot for the source
    a_credit_return: assert property (
        @(posedge sys_clk_in) disable iff (rst_in)
            in_credit |=> fifo_cnt == $past(fifo_cnt) + $past(res_valid) - 1'b1
    ) else $error("in_credit pulsed without a freed FIFO slot");

endmodule

/* bench/pid_tb.sv */
`timescale 1ns/1ns
`include "pid_macros.svh"

module pid_tb;
    import pid_pkg::*;

    localparam int     CLK_PERIOD = 8;
    localparam int     N_TESTS    = 5;
    localparam longint MAX_OUT    = (longint'(1) <<< (`PID_W_DATA_OUT - 1)) - 1;
    localparam longint MIN_OUT    = -(longint'(1) <<< (`PID_W_DATA_OUT - 1));

    logic                      sys_clk_in;
    logic                      rst_in;
    logic                      in_valid;
    chan_t                     in_chan;
    sample_t                   in_data;
    logic                      wr_en;
    pid_reg_t                  wr_addr;
    chan_t                     wr_chan;
    logic [`PID_W_WR_DATA-1:0] wr_data;
    logic                      out_credit = 1'b0;
    logic                      in_credit;
    logic                      out_valid;
    chan_t                     out_chan;
    out_t                      out_data;

    // Reference model state per channel
    longint m_sp   [`PID_N_CHAN];
    longint m_p    [`PID_N_CHAN];
    longint m_i    [`PID_N_CHAN];
    longint m_d    [`PID_N_CHAN];
    logic   m_lock [`PID_N_CHAN];
    longint m_e1   [`PID_N_CHAN];
    longint m_e2   [`PID_N_CHAN];
    longint m_prev [`PID_N_CHAN];

    // Expected results in output order
    chan_t exp_chan [$];
    out_t  exp_data [$];

    int          sent_count    = 0;
    int          credit_pulses = 0;
    int          out_count     = 0;
    out_t        last_out;
    logic        sink_hold     = 1'b0;
    logic        credit_due    = 1'b0;
    int          released      = 0;
    int          released_done = 0;
    logic        run_done      = 1'b0;
    int unsigned lcg_state;

    initial sys_clk_in = 1'b0;
    always #(CLK_PERIOD / 2) sys_clk_in = ~sys_clk_in;

    pid_top i_dut (
        .sys_clk_in (sys_clk_in),
        .rst_in     (rst_in),
        .in_valid   (in_valid),
        .in_chan    (in_chan),
        .in_data    (in_data),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_chan    (wr_chan),
        .wr_data    (wr_data),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_chan   (out_chan),
        .out_data   (out_data)
    );

    bind pid_top pid_checker i_checker (
        .sys_clk_in   (sys_clk_in),
        .rst_in       (rst_in),
        .res_valid    (res_valid),
        .out_valid    (out_valid),
        .out_credit   (out_credit),
        .in_credit    (in_credit),
        .sink_credits (i_out.sink_credits),
        .fifo_cnt     (i_out.fifo_cnt)
    );

    // --------------------------------------------------
    // Failure reporting and compares
    task automatic abort_run(input string why);
        run_done = 1'b1;
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_chan(input string name, input chan_t got, input chan_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compare_out(input string name, input out_t got, input out_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // Upper bits of the LCG are the better ones
    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;
    endfunction

    // Sample in -4096..4095
    function automatic sample_t rand_sample();
        return sample_t'(int'(next_rand() % 8192) - 4096);
    endfunction

    // --------------------------------------------------
    // Reference model of the incremental PID form
    function automatic void model_step(input chan_t c, input sample_t x);
        longint e;
        longint sum;
        longint acc;
        if (!m_lock[c]) begin
            // Lock off clears history and output
            m_e1[c]   = 0;
            m_e2[c]   = 0;
            m_prev[c] = 0;
        end else begin
            e   = m_sp[c] - longint'(x);
            sum = (m_p[c] + m_i[c] + m_d[c]) * e
                - (m_p[c] + 2 * m_d[c]) * m_e1[c]
                + m_d[c] * m_e2[c];
            acc = m_prev[c] + (sum >>> `PID_COEF_FRAC);
            if (acc > MAX_OUT) begin
                acc = MAX_OUT;
            end else if (acc < MIN_OUT) begin
                acc = MIN_OUT;
            end
            m_e2[c]   = m_e1[c];
            m_e1[c]   = e;
            m_prev[c] = acc;
        end
        exp_chan.push_back(c);
        exp_data.push_back(out_t'(m_prev[c]));
    endfunction

    // --------------------------------------------------
    // Bus drivers
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge sys_clk_in);
            in_valid <= 1'b0;
            wr_en    <= 1'b0;
        end
    endtask

    task automatic write_reg(input pid_reg_t addr, input chan_t c, input logic [31:0] data);
        @(posedge sys_clk_in);
        in_valid <= 1'b0;
        wr_en    <= 1'b1;
        wr_addr  <= addr;
        wr_chan  <= c;
        wr_data  <= data;
    endtask

    task automatic config_chan(input chan_t c, input sample_t sp, input coef_t p_coef,
                               input coef_t i_coef, input coef_t d_coef, input logic lock_en);
        write_reg(reg_setpoint, c, 32'(sp));
        write_reg(reg_p_coef, c, 32'(p_coef));
        write_reg(reg_i_coef, c, 32'(i_coef));
        write_reg(reg_d_coef, c, 32'(d_coef));
        write_reg(reg_lock_en, c, 32'(lock_en));
        m_sp[c]   = sp;
        m_p[c]    = p_coef;
        m_i[c]    = i_coef;
        m_d[c]    = d_coef;
        m_lock[c] = lock_en;
    endtask

    task automatic set_lock(input chan_t c, input logic lock_en);
        write_reg(reg_lock_en, c, 32'(lock_en));
        m_lock[c] = lock_en;
    endtask

    task automatic send_sample(input chan_t c, input sample_t x);
        @(posedge sys_clk_in);
        // Hold off while no source credit is left
        while (sent_count - credit_pulses >= `PID_FIFO_DEPTH) begin
            in_valid <= 1'b0;
            wr_en    <= 1'b0;
            @(posedge sys_clk_in);
        end
        in_valid <= 1'b1;
        in_chan  <= c;
        in_data  <= x;
        wr_en    <= 1'b0;
        sent_count++;
        model_step(c, x);
    endtask

    task automatic wait_drain();
        idle(1);
        while (exp_data.size() != 0) begin
            idle(1);
        end
        // Last credit back to the DUT
        idle(4);
    endtask

    // Held-back sink credits handed out one per cycle
    task automatic return_sink_credits(input int n);
        @(negedge sys_clk_in);
        released += n;
    endtask

    // --------------------------------------------------
    // Sink and output monitor
    always @(negedge sys_clk_in) begin
        credit_due = 1'b0;
        if (!rst_in) begin
            if (in_credit) begin
                credit_pulses++;
            end
            if (credit_pulses > sent_count) begin
                abort_run("in_credit pulsed with no sample outstanding");
            end
            if (out_valid) begin
                if (exp_data.size() == 0) begin
                    abort_run("An output appeared with no sample pending");
                end else begin
                    compare_chan("out_chan", out_chan, exp_chan.pop_front());
                    compare_out("out_data", out_data, exp_data.pop_front());
                    last_out = out_data;
                    out_count++;
                    credit_due = !sink_hold;
                end
            end
        end
    end

    // Credit goes back the cycle after a pop
    always @(posedge sys_clk_in) begin
        if (rst_in) begin
            out_credit <= 1'b0;
        end else if (credit_due) begin
            out_credit <= 1'b1;
        end else if (released_done < released) begin
            out_credit    <= 1'b1;
            released_done <= released_done + 1;
        end else begin
            out_credit <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Directed tests
    task automatic test_proportional();
        // Gain 1.0 and error 100 settle at 100
        config_chan(3'd2, 18'sd1000, 16'sd256, 16'sd0, 16'sd0, 1'b1);
        repeat (12) send_sample(3'd2, 18'sd900);
        wait_drain();
        compare_out("out_data", last_out, out_t'(100));
    endtask

    task automatic test_integral_derivative();
        // Integral only with a step in the sample halfway
        config_chan(3'd5, 18'sd500, 16'sd0, 16'sd64, 16'sd0, 1'b1);
        for (int n = 0; n < 16; n++) begin
            send_sample(3'd5, (n < 8) ? 18'sd400 : 18'sd700);
        end
        wait_drain();
        // Derivative only with a kick at the step
        config_chan(3'd5, 18'sd500, 16'sd0, 16'sd0, 16'sd512, 1'b1);
        for (int n = 0; n < 16; n++) begin
            send_sample(3'd5, (n < 8) ? 18'sd650 : 18'sd300);
        end
        wait_drain();
    endtask

    task automatic test_saturation();
        // Largest error with largest gains
        config_chan(3'd7, 18'sh1FFFF, 16'sh7FFF, 16'sh7FFF, 16'sh7FFF, 1'b1);
        repeat (90) send_sample(3'd7, 18'sh20000);
        wait_drain();
        compare_out("out_data", last_out, out_t'(MAX_OUT));
        // Reversed error runs down to the negative limit
        config_chan(3'd7, 18'sh20000, 16'sh7FFF, 16'sh7FFF, 16'sh7FFF, 1'b1);
        repeat (160) send_sample(3'd7, 18'sh1FFFF);
        wait_drain();
        compare_out("out_data", last_out, out_t'(MIN_OUT));
    endtask

    task automatic test_lock_interleave();
        chan_t   c;
        sample_t x;
        // Channels 1, 4 and 7 start with lock off
        for (int n = 0; n < `PID_N_CHAN; n++) begin
            config_chan(chan_t'(n), rand_sample(), coef_t'(next_rand() % 640),
                        coef_t'(next_rand() % 128), coef_t'(next_rand() % 256),
                        (n % 3) != 1);
        end
        repeat (31) begin
            c = chan_t'(next_rand() % `PID_N_CHAN);
            x = rand_sample();
            send_sample(c, x);
        end
        // Lock-off sample clears the saturated state left in channel 7
        send_sample(3'd7, rand_sample());
        // Re-enabled channels restart from cleared history
        set_lock(3'd1, 1'b1);
        set_lock(3'd4, 1'b1);
        set_lock(3'd7, 1'b1);
        set_lock(3'd0, 1'b0);
        send_sample(3'd7, rand_sample());
        repeat (31) begin
            c = chan_t'(next_rand() % `PID_N_CHAN);
            x = rand_sample();
            send_sample(c, x);
        end
        wait_drain();
    endtask

    task automatic test_backpressure();
        int base_out;
        config_chan(3'd3, 18'sd2000, 16'sd128, 16'sd32, 16'sd64, 1'b1);
        idle(4);
        base_out  = out_count;
        sink_hold = 1'b1;
        // Source runs until its credits are gone
        repeat (`PID_SINK_CREDITS + `PID_FIFO_DEPTH) send_sample(3'd3, rand_sample());
        idle(40);
        if (out_count - base_out != `PID_SINK_CREDITS) begin
            abort_run($sformatf("Saw %0d outputs while the sink held its credits, expected %0d",
                                out_count - base_out, `PID_SINK_CREDITS));
        end
        if (sent_count - credit_pulses != `PID_FIFO_DEPTH) begin
            abort_run("The source got credits back although the FIFO stayed full");
        end
        sink_hold = 1'b0;
        return_sink_credits(`PID_SINK_CREDITS);
        wait_drain();
    endtask

    // --------------------------------------------------
    initial begin
        lcg_state = 51;
        rst_in    = 1'b1;
        in_valid  = 1'b0;
        in_chan   = '0;
        in_data   = '0;
        wr_en     = 1'b0;
        wr_addr   = reg_setpoint;
        wr_chan   = '0;
        wr_data   = '0;
        for (int n = 0; n < `PID_N_CHAN; n++) begin
            m_sp[n]   = 0;
            m_p[n]    = 0;
            m_i[n]    = 0;
            m_d[n]    = 0;
            m_lock[n] = 1'b0;
            m_e1[n]   = 0;
            m_e2[n]   = 0;
            m_prev[n] = 0;
        end
        repeat (5) @(posedge sys_clk_in);
        rst_in <= 1'b0;
        test_proportional();
        test_integral_derivative();
        test_saturation();
        test_lock_interleave();
        test_backpressure();
        if (credit_pulses != out_count) begin
            abort_run("The number of in_credit pulses differs from the number of outputs");
        end else begin
            run_done = 1'b1;
            $display("Test passed");
            $finish;
        end
    end

    // Watchdog allows 2000 cycles per test
    initial begin
        #(N_TESTS * 2000 * CLK_PERIOD);
        abort_run("Timeout while waiting for the DUT");
    end

    final begin
        if (!run_done) begin
            $display("Test failed");
        end
    end

endmodule

/* hw/chan_state_ram.sv */
`timescale 1ns/1ns
`include "pid_macros.svh"

module chan_state_ram #(
    parameter type entry_t = logic
) (
    input  logic           sys_clk_in,
    input  logic           rst_in,
    input  pid_pkg::chan_t rd_chan,
    input  logic           wr_en,
    input  pid_pkg::chan_t wr_chan,
    input  entry_t         wr_data,
    output entry_t         rd_data
);

    // One entry per channel
    entry_t mem [`PID_N_CHAN];

    // Asynchronous read
    assign rd_data = mem[rd_chan];

    // Write on the clock edge
    // Reset zeroes every channel
    always_ff @(posedge sys_clk_in) begin
        if (rst_in) begin
            for (int n = 0; n < `PID_N_CHAN; n++) begin
                mem[n] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_chan] <= wr_data;
        end
    end

endmodule

/* hw/pid_config_regs.sv */
`timescale 1ns/1ns
`include "pid_macros.svh"

module pid_config_regs (
    input  logic                     sys_clk_in,
    input  logic                     rst_in,
    input  logic                     wr_en,
    input  pid_pkg::pid_reg_t        wr_addr,
    input  pid_pkg::chan_t           wr_chan,
    input  logic [`PID_W_WR_DATA-1:0] wr_data,
    input  pid_pkg::chan_t           rd_chan,
    output pid_pkg::coef_entry_t     coef
);
    import pid_pkg::*;

    coef_entry_t cur_entry;
    coef_entry_t new_entry;
    logic        addr_hit;
    logic        ram_we;

    // Merge the written field into the current entry
    always_comb begin
        new_entry = cur_entry;
        addr_hit  = 1'b1;
        case (wr_addr)
            reg_setpoint: new_entry.setpoint = wr_data[`PID_W_DATA_IN-1:0];
            reg_p_coef:   new_entry.p_coef   = wr_data[`PID_W_COEF-1:0];
            reg_i_coef:   new_entry.i_coef   = wr_data[`PID_W_COEF-1:0];
            reg_d_coef:   new_entry.d_coef   = wr_data[`PID_W_COEF-1:0];
            reg_lock_en:  new_entry.lock_en  = wr_data[0];
            // Unknown address, drop the write
            default:      addr_hit = 1'b0;
        endcase
    end

    assign ram_we = wr_en && addr_hit;

    // Filter-side copy, read by the stage-1 channel
    chan_state_ram #(
        .entry_t (coef_entry_t)
    ) i_coef_ram (
        .sys_clk_in (sys_clk_in),
        .rst_in     (rst_in),
        .rd_chan    (rd_chan),
        .wr_en      (ram_we),
        .wr_chan    (wr_chan),
        .wr_data    (new_entry),
        .rd_data    (coef)
    );

    // Shadow copy, read by the write channel for the merge
    // Keeps the filter read port free during writes
    chan_state_ram #(
        .entry_t (coef_entry_t)
    ) i_shadow_ram (
        .sys_clk_in (sys_clk_in),
        .rst_in     (rst_in),
        .rd_chan    (wr_chan),
        .wr_en      (ram_we),
        .wr_chan    (wr_chan),
        .wr_data    (new_entry),
        .rd_data    (cur_entry)
    );

endmodule

/* hw/pid_filter.sv */
`timescale 1ns/1ns
`include "pid_macros.svh"

module pid_filter (
    input  logic                 sys_clk_in,
    input  logic                 rst_in,
    input  logic                 in_valid,
    input  pid_pkg::chan_t       in_chan,
    input  pid_pkg::sample_t     in_data,
    input  pid_pkg::coef_entry_t coef,
    output pid_pkg::chan_t       coef_chan,
    output logic                 res_valid,
    output pid_pkg::chan_t       res_chan,
    output pid_pkg::out_t        res_data
);
    import pid_pkg::*;

    // --------------------------------------------------
    // Widths
    // k2 = -p - 2d needs two extra bits
    localparam int W_K    = `PID_W_COEF + 2;
    localparam int W_PROD = W_K + $bits(err_t);
    // Sum of three products
    localparam int W_SUM  = W_PROD + 2;
    localparam int W_ACC  = ((W_SUM > `PID_W_DATA_OUT) ? W_SUM : `PID_W_DATA_OUT) + 1;

    localparam out_t MAX_OUT = {1'b0, {(`PID_W_DATA_OUT-1){1'b1}}};
    localparam out_t MIN_OUT = {1'b1, {(`PID_W_DATA_OUT-1){1'b0}}};

    // --------------------------------------------------
    // Pipeline registers
    logic valid_p1, valid_p2, valid_p3, valid_p4, valid_p5, valid_p6;
    chan_t chan_p1, chan_p2, chan_p3, chan_p4, chan_p5, chan_p6;
    logic lock_p2, lock_p3, lock_p4, lock_p5;

    sample_t                   data_p1;
    coef_entry_t               coef_p1;
    err_t                      error_p2;
    logic signed [W_K-1:0]     k1_p2, k2_p2, k3_p2;
    hist_entry_t               hist_p2;
    logic signed [W_PROD-1:0]  prod0_p3, prod1_p3, prod2_p3;
    logic signed [W_SUM-1:0]   sum_p4;
    out_t                      prev_p4;
    logic signed [W_ACC-1:0]   data_p5;
    out_t                      data_p6;

    // Stage logic
    err_t        error_c;
    hist_entry_t hist_rd, hist_fwd, hist_wr;
    out_t        prev_rd, prev_fwd, prev_sel, out_wr;

    // Coefficients come back combinationally for stage 1
    assign coef_chan = in_chan;

    // Stage 2 error, zero with lock off
    always_comb begin
        error_c = coef_p1.setpoint - data_p1;
        if (!coef_p1.lock_en) begin
            error_c = '0;
        end
    end

    // History write data from stage 3
    always_comb begin
        hist_wr = '0;
        if (lock_p2) begin
            hist_wr.err0 = error_p2;
            hist_wr.err1 = hist_p2.err0;
        end
    end

    // Same channel one ahead, history not yet in the RAM
    assign hist_fwd = (valid_p2 && chan_p2 == chan_p1) ? hist_wr : hist_rd;

    // Stage 6 saturation, lock off gives 0
    always_comb begin
        if (!lock_p5) begin
            out_wr = '0;
        end else if (data_p5 > MAX_OUT) begin
            out_wr = MAX_OUT;
        end else if (data_p5 < MIN_OUT) begin
            out_wr = MIN_OUT;
        end else begin
            out_wr = data_p5[`PID_W_DATA_OUT-1:0];
        end
    end

    // Stage 4 read, two ahead still in stage 5
    assign prev_fwd = (valid_p5 && chan_p5 == chan_p3) ? out_wr : prev_rd;
    // Stage 5 use, one ahead just saturating
    assign prev_sel = (valid_p5 && chan_p5 == chan_p4) ? out_wr : prev_p4;

    // --------------------------------------------------
    // Valid chain
    always_ff @(posedge sys_clk_in) begin
        if (rst_in) begin
            valid_p1 <= 1'b0;
            valid_p2 <= 1'b0;
            valid_p3 <= 1'b0;
            valid_p4 <= 1'b0;
            valid_p5 <= 1'b0;
            valid_p6 <= 1'b0;
        end else begin
            valid_p1 <= in_valid;
            valid_p2 <= valid_p1;
            valid_p3 <= valid_p2;
            valid_p4 <= valid_p3;
            valid_p5 <= valid_p4;
            valid_p6 <= valid_p5;
        end
    end

    // Datapath
    always_ff @(posedge sys_clk_in) begin
        // Stage 1, sample and coefficients
        chan_p1 <= in_chan;
        data_p1 <= in_data;
        coef_p1 <= coef;
        // Stage 2, error, z-transform gains, history
        chan_p2  <= chan_p1;
        lock_p2  <= coef_p1.lock_en;
        error_p2 <= error_c;
        k1_p2    <= coef_p1.p_coef + coef_p1.i_coef + coef_p1.d_coef;
        k2_p2    <= -coef_p1.p_coef - (coef_p1.d_coef <<< 1);
        k3_p2    <= coef_p1.d_coef;
        hist_p2  <= hist_fwd;
        // Stage 3, products
        chan_p3  <= chan_p2;
        lock_p3  <= lock_p2;
        prod0_p3 <= k1_p2 * error_p2;
        prod1_p3 <= k2_p2 * hist_p2.err0;
        prod2_p3 <= k3_p2 * hist_p2.err1;
        // Stage 4, sum and previous output
        chan_p4 <= chan_p3;
        lock_p4 <= lock_p3;
        sum_p4  <= prod0_p3 + prod1_p3 + prod2_p3;
        prev_p4 <= prev_fwd;
        // Stage 5, scaled increment onto previous output
        chan_p5 <= chan_p4;
        lock_p5 <= lock_p4;
        data_p5 <= prev_sel + (sum_p4 >>> `PID_COEF_FRAC);
        // Stage 6, saturated result
        chan_p6 <= chan_p5;
        data_p6 <= out_wr;
    end

    // Error history, written from stage 3
    chan_state_ram #(
        .entry_t (hist_entry_t)
    ) i_hist_ram (
        .sys_clk_in (sys_clk_in),
        .rst_in     (rst_in),
        .rd_chan    (chan_p1),
        .wr_en      (valid_p2),
        .wr_chan    (chan_p2),
        .wr_data    (hist_wr),
        .rd_data    (hist_rd)
    );

    // Previous output, written from stage 6
    chan_state_ram #(
        .entry_t (out_t)
    ) i_prev_ram (
        .sys_clk_in (sys_clk_in),
        .rst_in     (rst_in),
        .rd_chan    (chan_p3),
        .wr_en      (valid_p5),
        .wr_chan    (chan_p5),
        .wr_data    (out_wr),
        .rd_data    (prev_rd)
    );

    assign res_valid = valid_p6;
    assign res_chan  = chan_p6;
    assign res_data  = data_p6;

endmodule

/* hw/pid_out_credit.sv */
`timescale 1ns/1ns
`include "pid_macros.svh"

module pid_out_credit (
    input  logic           sys_clk_in,
    input  logic           rst_in,
    input  logic           res_valid,
    input  pid_pkg::chan_t res_chan,
    input  pid_pkg::out_t  res_data,
    input  logic           out_credit,
    output logic           out_valid,
    output pid_pkg::chan_t out_chan,
    output pid_pkg::out_t  out_data,
    output logic           in_credit
);
    import pid_pkg::*;

    localparam int W_PTR  = $clog2(`PID_FIFO_DEPTH);
    localparam int W_CNT  = $clog2(`PID_FIFO_DEPTH + 1);
    localparam int W_CRED = $clog2(`PID_SINK_CREDITS + 1);

    // FIFO storage
    chan_t chan_mem [`PID_FIFO_DEPTH];
    out_t  data_mem [`PID_FIFO_DEPTH];

    logic [W_PTR-1:0]  wr_ptr, rd_ptr;
    logic [W_CNT-1:0]  fifo_cnt;
    logic [W_CRED-1:0] sink_credits;
    logic              pop;

    // Pop when data waits and the sink has room
    assign pop = (fifo_cnt != '0) && (sink_credits != '0);

    // --------------------------------------------------
    // Storage, no overflow check
    // Source credits bound occupancy
    always_ff @(posedge sys_clk_in) begin
        if (res_valid) begin
            chan_mem[wr_ptr] <= res_chan;
            data_mem[wr_ptr] <= res_data;
        end
    end

    // Pointers, occupancy and sink credits
    always_ff @(posedge sys_clk_in) begin
        if (rst_in) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fifo_cnt     <= '0;
            sink_credits <= W_CRED'(`PID_SINK_CREDITS);
        end else begin
            if (res_valid) begin
                wr_ptr <= (wr_ptr == W_PTR'(`PID_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == W_PTR'(`PID_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({res_valid, pop})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase
            // Returned credit and spent credit cancel
            case ({out_credit, pop})
                2'b10:   sink_credits <= sink_credits + 1'b1;
                2'b01:   sink_credits <= sink_credits - 1'b1;
                default: sink_credits <= sink_credits;
            endcase
        end
    end

    // --------------------------------------------------
    // Head of FIFO straight to the sink
    assign out_valid = pop;
    assign out_chan  = chan_mem[rd_ptr];
    assign out_data  = data_mem[rd_ptr];
    // Freed slot goes back to the source
    assign in_credit = pop;

endmodule

/* hw/pid_pkg.sv */
`include "pid_macros.svh"

package pid_pkg;

    // Scalar types
    typedef logic signed [`PID_W_DATA_IN-1:0]  sample_t;
    typedef logic        [`PID_W_CHAN-1:0]     chan_t;
    typedef logic signed [`PID_W_COEF-1:0]     coef_t;
    typedef logic signed [`PID_W_DATA_OUT-1:0] out_t;
    // One bit wider than a sample, so setpoint minus sample never wraps
    typedef logic signed [`PID_W_DATA_IN:0]    err_t;

    // Per-channel configuration entry
    typedef struct packed {
        sample_t setpoint;
        coef_t   p_coef;
        coef_t   i_coef;
        coef_t   d_coef;
        logic    lock_en;
    } coef_entry_t;

    // Error history, err0 is e[n-1] and err1 is e[n-2]
    typedef struct packed {
        err_t err1;
        err_t err0;
    } hist_entry_t;

    // Configuration register addresses
    typedef enum logic [2:0] {
        reg_setpoint = 3'd0,
        reg_p_coef   = 3'd1,
        reg_i_coef   = 3'd2,
        reg_d_coef   = 3'd3,
        reg_lock_en  = 3'd4
    } pid_reg_t;

endpackage

/* hw/pid_top.sv */
`timescale 1ns/1ns
`include "pid_macros.svh"

module pid_top (
    input  logic                      sys_clk_in,
    input  logic                      rst_in,
    input  logic                      in_valid,
    input  pid_pkg::chan_t            in_chan,
    input  pid_pkg::sample_t          in_data,
    input  logic                      wr_en,
    input  pid_pkg::pid_reg_t         wr_addr,
    input  pid_pkg::chan_t            wr_chan,
    input  logic [`PID_W_WR_DATA-1:0] wr_data,
    input  logic                      out_credit,
    output logic                      in_credit,
    output logic                      out_valid,
    output pid_pkg::chan_t            out_chan,
    output pid_pkg::out_t             out_data
);
    import pid_pkg::*;

    // Coefficient fetch
    coef_entry_t coef;
    chan_t       coef_chan;
    // Filter results into the FIFO
    logic        res_valid;
    chan_t       res_chan;
    out_t        res_data;

    pid_config_regs i_config (
        .sys_clk_in (sys_clk_in),
        .rst_in     (rst_in),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_chan    (wr_chan),
        .wr_data    (wr_data),
        .rd_chan    (coef_chan),
        .coef       (coef)
    );

    pid_filter i_filter (
        .sys_clk_in (sys_clk_in),
        .rst_in     (rst_in),
        .in_valid   (in_valid),
        .in_chan    (in_chan),
        .in_data    (in_data),
        .coef       (coef),
        .coef_chan  (coef_chan),
        .res_valid  (res_valid),
        .res_chan   (res_chan),
        .res_data   (res_data)
    );

    pid_out_credit i_out (
        .sys_clk_in (sys_clk_in),
        .rst_in     (rst_in),
        .res_valid  (res_valid),
        .res_chan   (res_chan),
        .res_data   (res_data),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_chan   (out_chan),
        .out_data   (out_data),
        .in_credit  (in_credit)
    );

endmodule

/* include/pid_macros.svh */
`ifndef PID_MACROS_SVH
`define PID_MACROS_SVH

// Channel count and channel index width
`define PID_N_CHAN        8
`define PID_W_CHAN        3

// Signed sample and setpoint width
`define PID_W_DATA_IN     18

// Signed coefficient width
`define PID_W_COEF        16
// Fraction bits of P, I and D
`define PID_COEF_FRAC     8

// Signed result width after saturation
`define PID_W_DATA_OUT    32

// Configuration data bus width
`define PID_W_WR_DATA     32

// Output FIFO entries, also the source credit count after reset
`define PID_FIFO_DEPTH    8
// Sink credits held after reset
`define PID_SINK_CREDITS  4

`endif

/* project.f */
+incdir+include
hw/pid_pkg.sv
hw/chan_state_ram.sv
hw/pid_config_regs.sv
hw/pid_filter.sv
hw/pid_out_credit.sv
hw/pid_top.sv
bench/pid_checker.sv
bench/pid_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the PID testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module pid_tb -f project.f -o pid_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/pid_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
